/* Makefile */
TOP := desc_path_tb
OBJ := obj_dir

.PHONY: all lint clean

# Build, run, then decide from the log
all: $(OBJ)/V$(TOP)
	./$(OBJ)/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Simulation failed" sim.log; then exit 1; fi
	@grep -q "Simulation passed" sim.log

$(OBJ)/V$(TOP): compile.f src/*.sv verif/*.sv
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir $(OBJ)

lint:
	verilator --lint-only --timing --assert -Wall -f compile.f --top-module $(TOP)

clean:
	rm -rf $(OBJ) sim.log

/* compile.f */
src/desc_pkg.sv
src/desc_ingress.sv
src/desc_fifo.sv
src/desc_egress.sv
src/desc_path.sv
verif/desc_path_tb.sv

/* src/desc_egress.sv */
`timescale 1ns/100ps
`default_nettype none

module desc_egress
    import desc_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      out_ready,
    input  logic      empty,
    input  pkt_desc_t head_desc,
    output logic      pop,
    output logic      out_valid,
    output pkt_desc_t out_desc
);

    // ==============================
    // Pop decision
    // ==============================

    // Combinational, takes the head in the same cycle
    assign pop = out_ready && !empty;

    // ==============================
    // Output register
    // ==============================

    // One-cycle strobe per popped entry
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= pop;
        end
    end

    // Payload captured at the pop edge
    always_ff @(posedge clk) begin
        if (pop) begin
            out_desc <= head_desc;
        end
    end

    // Strobe only ever follows a pop
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> $past(pop))
    else $error("desc_egress: out_valid without pop");

endmodule

`default_nettype wire

/* src/desc_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module desc_fifo
    import desc_pkg::*;
#(
    parameter int unsigned DEPTH = 8
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       push,
    input  pkt_desc_t                  push_desc,
    input  logic                       pop,
    output pkt_desc_t                  head_desc,
    output logic                       full,
    output logic                       empty,
    output logic [$clog2(DEPTH):0]     level
);

    // ==============================
    // Storage and pointers
    // ==============================

    localparam int unsigned AW = $clog2(DEPTH);

    // Extra top bit tells a wrapped pointer apart
    typedef logic [AW:0]   ptr_t;
    typedef logic [AW-1:0] idx_t;

    pkt_desc_t mem [DEPTH];
    ptr_t      wr_ptr;
    ptr_t      rd_ptr;
    idx_t      wr_idx;
    idx_t      rd_idx;

    assign wr_idx = wr_ptr[AW-1:0];
    assign rd_idx = rd_ptr[AW-1:0];

    // Entry write, memory has no reset
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_idx] <= push_desc;
        end
    end

    // Pointer update, push and pop may share a cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // ==============================
    // Status
    // ==============================

    // Show-ahead read of the oldest entry
    assign head_desc = mem[rd_idx];

    // Same index, top bits differ -> wrapped once
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_idx == rd_idx);
    assign empty = (wr_ptr == rd_ptr);
    assign level = wr_ptr - rd_ptr;

    // Ingress owns the full decision
    assert property (@(posedge clk) disable iff (!rst_n) push |-> !full)
    else $error("desc_fifo: push while full");

    // Egress owns the empty decision
    assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty)
    else $error("desc_fifo: pop while empty");

    assert property (@(posedge clk) disable iff (!rst_n) level <= DEPTH)
    else $error("desc_fifo: level above DEPTH");

endmodule

`default_nettype wire

/* src/desc_ingress.sv */
`timescale 1ns/100ps
`default_nettype none

module desc_ingress
    import desc_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    input  pkt_desc_t in_desc,
    input  logic      full,
    output logic      push,
    output pkt_desc_t push_desc,
    output drop_cnt_t err_drops,
    output drop_cnt_t ovf_drops
);

    // ==============================
    // Input check
    // ==============================

    logic      malformed;
    logic      cand_valid;
    pkt_desc_t cand_desc;
    logic      overflow;

    // Zero length or misaligned address
    assign malformed = (in_desc.len == '0) ||
                       (in_desc.addr[DESC_ALIGN_BITS-1:0] != '0);

    // ==============================
    // Push register
    // ==============================

    // Well-formed descriptor held for one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cand_valid <= 1'b0;
        end else begin
            cand_valid <= in_valid && !malformed;
        end
    end

    // Payload, no reset
    always_ff @(posedge clk) begin
        if (in_valid) begin
            cand_desc <= in_desc;
        end
    end

    // Full is tested here, one cycle after the strobe, so an
    // earlier pending push is already counted in it
    assign overflow  = cand_valid && full;
    assign push      = cand_valid && !full;
    assign push_desc = cand_desc;

    // ==============================
    // Drop counters
    // ==============================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            err_drops <= '0;
            ovf_drops <= '0;
        end else begin
            // Malformed counted at the strobe
            if (in_valid && malformed) begin
                err_drops <= sat_inc(err_drops);
            end
            // Overflow counted at the push slot
            if (overflow) begin
                ovf_drops <= sat_inc(ovf_drops);
            end
        end
    end

    // Good length checked a cycle earlier, still good at push
    assert property (@(posedge clk) disable iff (!rst_n)
        push |-> (push_desc.len != '0))
    else $error("desc_ingress: push with zero length");

endmodule

`default_nettype wire

/* src/desc_path.sv */
`timescale 1ns/100ps
`default_nettype none

module desc_path
    import desc_pkg::*;
#(
    parameter int unsigned DEPTH = 8
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  pkt_desc_t              in_desc,
    input  logic                   out_ready,
    output logic                   out_valid,
    output pkt_desc_t              out_desc,
    output drop_cnt_t              err_drops,
    output drop_cnt_t              ovf_drops,
    output logic [$clog2(DEPTH):0] level
);

    // Ingress to FIFO
    logic      push;
    pkt_desc_t push_desc;
    logic      full;

    // FIFO to egress
    logic      pop;
    logic      empty;
    pkt_desc_t head_desc;

    // ==============================
    // Check and drop
    // ==============================
    desc_ingress desc_ingress_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_desc   (in_desc),
        .full      (full),
        .push      (push),
        .push_desc (push_desc),
        .err_drops (err_drops),
        .ovf_drops (ovf_drops)
    );

    // Descriptor store, DEPTH set here
    desc_fifo #(
        .DEPTH (DEPTH)
    ) desc_fifo_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_desc (push_desc),
        .pop       (pop),
        .head_desc (head_desc),
        .full      (full),
        .empty     (empty),
        .level     (level)
    );

    // ==============================
    // Hand-out under ready
    // ==============================
    desc_egress desc_egress_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .out_ready (out_ready),
        .empty     (empty),
        .head_desc (head_desc),
        .pop       (pop),
        .out_valid (out_valid),
        .out_desc  (out_desc)
    );

endmodule

`default_nettype wire

/* src/desc_pkg.sv */
`default_nettype none

package desc_pkg;

    // ==============================
    // Descriptor field types
    // ==============================

    // Buffer byte address
    typedef logic [31:0] addr_t;

    // Buffer length in bytes
    typedef logic [15:0] len_t;

    // Opaque per-packet metadata
    typedef logic [15:0] meta_t;

    // One descriptor, 64 bits, addr in the top bits
    typedef struct packed {
        addr_t addr;
        len_t  len;
        meta_t meta;
    } pkt_desc_t;

    // Saturating event counter
    typedef logic [15:0] drop_cnt_t;

    // Low address bits that must be clear (word alignment)
    localparam int unsigned DESC_ALIGN_BITS = 2;

    // Increment that holds at all ones
    function automatic drop_cnt_t sat_inc(drop_cnt_t cnt);
        if (&cnt) begin
            return cnt;
        end
        return drop_cnt_t'(cnt + 1'b1);
    endfunction

endpackage

`default_nettype wire

/* verif/desc_path_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module desc_path_tb
    import desc_pkg::*;
();

    localparam int unsigned DEPTH   = 8;
    localparam int unsigned TIMEOUT = 2000;

    logic                   clk;
    logic                   rst_n;
    logic                   in_valid;
    pkt_desc_t              in_desc;
    logic                   out_ready;
    logic                   out_valid;
    pkt_desc_t              out_desc;
    drop_cnt_t              err_drops;
    drop_cnt_t              ovf_drops;
    logic [$clog2(DEPTH):0] level;

    // Reference model state
    pkt_desc_t   exp_q[$];
    int unsigned occ;
    logic        pend;
    pkt_desc_t   pend_desc;
    logic        prev_ready;
    drop_cnt_t   exp_err;
    drop_cnt_t   exp_ovf;

    int unsigned errors = 0;
    int unsigned fails  = 0;
    logic [31:0] lfsr   = 32'h4ff6e265;

    desc_path #(
        .DEPTH (DEPTH)
    ) desc_path_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_desc   (in_desc),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .out_desc  (out_desc),
        .err_drops (err_drops),
        .ovf_drops (ovf_drops),
        .level     (level)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ==============================
    // Helpers
    // ==============================

    task automatic log_mismatch(input string name, input logic [63:0] exp,
                                input logic [63:0] act);
        $display("** Error: %s expected %h got %h", name, exp, act);
        errors++;
    endtask

    task automatic count_failure(input string msg);
        $display("Failure: %s", msg);
        fails++;
    endtask

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int unsigned n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // Descriptor rules: nonzero length, aligned address
    function automatic logic is_well_formed(input pkt_desc_t d);
        return (d.len != '0) && (d.addr[DESC_ALIGN_BITS-1:0] == '0);
    endfunction

    function automatic pkt_desc_t good_desc();
        pkt_desc_t d;
        d.addr = rand_bits(32);
        d.addr[DESC_ALIGN_BITS-1:0] = '0;
        d.len  = len_t'(rand_bits(16));
        if (d.len == '0) begin
            d.len = 16'd64;
        end
        d.meta = meta_t'(rand_bits(16));
        return d;
    endfunction

    task automatic send_desc(input pkt_desc_t d);
        @(posedge clk);
        in_valid <= 1'b1;
        in_desc  <= d;
    endtask

    task automatic wait_out_valid(output int unsigned cycles);
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!out_valid && cycles < TIMEOUT);
        if (!out_valid) begin
            count_failure("timeout waiting for out_valid");
        end
    endtask

    // Mid-cycle polling keeps clear of the model's edge updates
    task automatic wait_pending_clear();
        int unsigned guard;
        guard = 0;
        do begin
            @(negedge clk);
            guard++;
        end while (pend && guard < TIMEOUT);
        if (pend) begin
            count_failure("timeout waiting for the ingress register to empty");
        end
    endtask

    task automatic drain();
        int unsigned guard;
        guard = 0;
        do begin
            @(negedge clk);
            guard++;
        end while ((exp_q.size() != 0 || pend || out_valid || level != 0) &&
                   guard < TIMEOUT);
        if (exp_q.size() != 0 || pend || out_valid || level != 0) begin
            count_failure("timeout while draining the descriptor path");
        end
    endtask

    task automatic check_counters();
        assert (err_drops == exp_err)
        else log_mismatch("err_drops", 64'(exp_err), 64'(err_drops));
        assert (ovf_drops == exp_ovf)
        else log_mismatch("ovf_drops", 64'(exp_ovf), 64'(ovf_drops));
    endtask

    // ==============================
    // Model and output checks
    // ==============================

    always @(posedge clk) begin
        pkt_desc_t exp_d;
        logic      m_pop;
        if (!rst_n) begin
            occ        = 0;
            pend       = 1'b0;
            prev_ready = 1'b1;
            exp_err    = '0;
            exp_ovf    = '0;
        end else begin
            assert (level == occ) else log_mismatch("level", 64'(occ), 64'(level));
            assert (!(out_valid && !prev_ready))
            else count_failure("out_valid high in the cycle after out_ready low");
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    count_failure("out_valid with no descriptor expected");
                end else begin
                    exp_d = exp_q.pop_front();
                    assert (out_desc == exp_d)
                    else log_mismatch("out_desc", exp_d, out_desc);
                end
            end
            // FIFO occupancy before this edge decides pop and overflow
            m_pop = out_ready && (occ != 0);
            if (pend) begin
                if (occ == DEPTH) begin
                    if (exp_ovf != '1) exp_ovf++;
                end else begin
                    exp_q.push_back(pend_desc);
                    occ++;
                end
            end
            if (m_pop) begin
                occ--;
            end
            pend      = in_valid && is_well_formed(in_desc);
            pend_desc = in_desc;
            if (in_valid && !is_well_formed(in_desc) && exp_err != '1) begin
                exp_err++;
            end
            prev_ready = out_ready;
        end
    end

    // ==============================
    // Stimulus
    // ==============================

    initial begin
        int unsigned sent;
        int unsigned lat;
        pkt_desc_t   d;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_desc   = '0;
        out_ready = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        // Idle state right after reset
        repeat (4) begin
            @(posedge clk);
            assert (!out_valid) else count_failure("out_valid high after reset");
            assert (level == 0) else log_mismatch("level", 64'd0, 64'(level));
            check_counters();
        end

        // Single descriptor, empty FIFO, ready high
        out_ready <= 1'b1;
        send_desc(good_desc());
        @(posedge clk);
        in_valid <= 1'b0;
        wait_out_valid(lat);
        assert (lat == 3) else log_mismatch("latency", 64'd3, 64'(lat));
        drain();

        // Random good stream under random back-pressure
        sent = 0;
        while (sent < 200) begin
            @(posedge clk);
            out_ready <= 1'(rand_bits(1));
            if (rand_bits(2) != 0) begin
                d = good_desc();
                in_valid <= 1'b1;
                in_desc  <= d;
                sent++;
            end else begin
                in_valid <= 1'b0;
            end
        end
        @(posedge clk);
        in_valid  <= 1'b0;
        out_ready <= 1'b1;
        drain();
        check_counters();

        // Malformed mix, zero length or misaligned address
        for (int i = 0; i < 60; i++) begin
            d = good_desc();
            case (2'(rand_bits(2)))
                2'd0: d.len = '0;
                2'd1: d.addr[0] = 1'b1;
                2'd2: d.addr[DESC_ALIGN_BITS-1] = 1'b1;
                default: d.meta = ~d.meta;
            endcase
            send_desc(d);
        end
        @(posedge clk);
        in_valid <= 1'b0;
        drain();
        check_counters();

        // Overflow with ready held low
        @(posedge clk);
        out_ready <= 1'b0;
        for (int i = 0; i < DEPTH + 5; i++) begin
            send_desc(good_desc());
        end
        @(posedge clk);
        in_valid <= 1'b0;
        wait_pending_clear();
        assert (level == DEPTH) else log_mismatch("level", 64'(DEPTH), 64'(level));
        check_counters();
        @(posedge clk);
        out_ready <= 1'b1;
        drain();
        check_counters();

        $display("Mismatches: %0d, other failures: %0d", errors, fails);
        if (errors == 0 && fails == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
